/* flist.f */
+incdir+source
source/tlb_pkg.sv
source/tlb_entry_array.sv
source/tlb_match_stage.sv
source/tlb_translate_stage.sv
source/tlb.sv
dv/tb_tlb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       := tb_tlb
FLIST     := flist.f
OBJ_DIR   := obj_dir
VFLAGS    := --binary --timing --assert -j 0
SIM       := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(wildcard source/*.sv source/*.svh dv/*.sv)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FLIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)

/* dv/tb_tlb.sv */
`include "tlb_config.svh"

module tb_tlb
    import tlb_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int N_DIRECT = 20;
    localparam int N_WIN    = 10;
    localparam int N_MAP    = 12;   // Entries outside the windowed segments.
    localparam int N_RAND   = 60;
    localparam int TEST_CYCLES = 8 + N_DIRECT + 2 * N_WIN + 4 * N_MAP + N_MAP / 2 + 6 + N_RAND;
    localparam int LIMIT = 2 * TEST_CYCLES + 100;

    typedef struct packed {
        logic [63:0] due;           // Negedge time of the result.
        tlb_result_t f_exp;
        tlb_result_t d_exp;
    } pend_t;

    logic        clk;
    logic        rstn;
    asid_t       csr_asid;
    logic        pg;
    seg_t        dmw0_vseg, dmw0_pseg, dmw1_vseg, dmw1_pseg;
    logic        tlb_we;
    tlb_idx_t    tlb_windex;
    tlb_entry_t  tlb_wentry;
    tlb_req_t    fetch_req, data_req;
    tlb_result_t fetch_res, data_res;

    tlb_entry_t  shadow [`TLB_NUM];
    pend_t       pend_q [$];
    logic [31:0] lfsr;
    int unsigned cycles;
    // Values for the next edge.
    tlb_req_t    f_nxt, d_nxt;
    logic        we_nxt;
    tlb_idx_t    idx_nxt;
    tlb_entry_t  ent_nxt;
    asid_t       asid_nxt;

    tlb i_dut (.*);

    always #5 clk = ~clk;

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v = {v[30:0], lfsr[0]};
        end
    endtask

    // Expected port result from the shadow entries and the current mode.
    function automatic tlb_result_t ref_xlat(input vaddr_t va, input asid_t asid);
        tlb_result_t r;
        tlb_half_t   h;
        tlb_entry_t  e;
        logic        hit;
        int          ps;
        int          sh;
        logic [31:0] off_mask;
        r = '0;
        r.valid = 1'b1;
        r.d = 1'b1;
        if (!pg) begin
            r.pa = va;
        end else if (va[31:29] == dmw0_vseg) begin
            r.pa = {dmw0_pseg, va[28:0]};
        end else if (va[31:29] == dmw1_vseg) begin
            r.pa = {dmw1_pseg, va[28:0]};
        end else begin
            hit = 1'b0;
            h = '0;
            ps = `TLB_PS_4K;
            for (int i = 0; i < `TLB_NUM; i++) begin
                e = shadow[i];
                sh = (e.ps == 6'(`TLB_PS_4M)) ? `TLB_PS_4M + 1 : `TLB_PS_4K + 1;
                if (e.e && (e.g || e.asid == asid) && (va >> sh) == ({e.vppn, 13'b0} >> sh)) begin
                    hit = 1'b1;
                    ps = sh - 1;
                    h = va[sh - 1] ? e.odd : e.even;    // Odd half when the bit is set.
                end
            end
            off_mask = (32'd1 << ps) - 32'd1;
            r.pa = ({h.ppn, 12'b0} & ~off_mask) | (va & off_mask);
            r.refill = !hit;
            r.invalid = hit && !h.v;
            r.mat = h.mat;
            r.plv = h.plv;
            r.d = h.d;
        end
        return r;
    endfunction

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("Simulation failed");
        $fatal(1, "run stopped");
    endtask

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            stop_run($sformatf("Error: time %0t: %s is 0x%0h, expected 0x%0h",
                               $time, name, got, exp));
        end
    endtask

    task automatic compare_port(input string name, input tlb_result_t got,
                                input tlb_result_t exp);
        if (got.valid && !exp.valid) begin
            stop_run($sformatf("%s shows a valid result with no request pending", name));
        end else if (!got.valid && exp.valid) begin
            stop_run($sformatf("%s result is missing at its due edge", name));
        end else begin
            check_val({name, ".pa"}, got.pa, exp.pa);
            check_val({name, ".refill"}, 32'(got.refill), 32'(exp.refill));
            check_val({name, ".invalid"}, 32'(got.invalid), 32'(exp.invalid));
            check_val({name, ".mat"}, 32'(got.mat), 32'(exp.mat));
            check_val({name, ".plv"}, 32'(got.plv), 32'(exp.plv));
            check_val({name, ".d"}, 32'(got.d), 32'(exp.d));
        end
    endtask

    // One edge of stimulus. Expected values use the entries before this write.
    task automatic tick();
        pend_t p;
        @(posedge clk);
        p.due = $time + 64'd25;
        p.f_exp = f_nxt.valid ? ref_xlat(f_nxt.va, asid_nxt) : '0;
        p.d_exp = d_nxt.valid ? ref_xlat(d_nxt.va, asid_nxt) : '0;
        if (f_nxt.valid || d_nxt.valid) begin
            pend_q.push_back(p);
        end
        fetch_req  <= f_nxt;
        data_req   <= d_nxt;
        csr_asid   <= asid_nxt;
        tlb_we     <= we_nxt;
        tlb_windex <= idx_nxt;
        tlb_wentry <= ent_nxt;
        if (we_nxt) begin
            shadow[idx_nxt] = ent_nxt;
        end
        f_nxt.valid = 1'b0;
        d_nxt.valid = 1'b0;
        we_nxt = 1'b0;
    endtask

    // Mode inputs change only with the pipeline empty.
    task automatic set_mode(input logic p, input seg_t v0, input seg_t p0,
                            input seg_t v1, input seg_t p1);
        while (pend_q.size() > 0) begin
            tick();
        end
        @(posedge clk);
        pg        <= p;
        dmw0_vseg <= v0;
        dmw0_pseg <= p0;
        dmw1_vseg <= v1;
        dmw1_pseg <= p1;
    endtask

    task automatic rand_va(output tlb_req_t q);
        logic [31:0] r;
        take_bits(32, r);
        q = {1'b1, r};
    endtask

    // VPPN top nibble is the index, so entries never overlap.
    task automatic make_entry(input tlb_idx_t idx, input logic big, output tlb_entry_t ent);
        logic [31:0] r;
        ent = '0;
        ent.e = 1'b1;
        take_bits(10, r);
        ent.asid = r[9:0];
        ent.g = idx[0];
        ent.ps = big ? 6'(`TLB_PS_4M) : 6'(`TLB_PS_4K);
        take_bits(15, r);
        ent.vppn = {idx, r[14:0]};
        take_bits(26, r);
        ent.even = r[25:0];
        ent.even.v = 1'b1;
        take_bits(26, r);
        ent.odd = r[25:0];
        ent.odd.v = 1'b1;
    endtask

    task automatic hit_va(input tlb_idx_t idx, input logic odd, output vaddr_t va);
        logic [31:0] r;
        tlb_entry_t  e;
        e = shadow[idx];
        take_bits(22, r);
        if (e.ps == 6'(`TLB_PS_4M)) begin
            va = {e.vppn[18:9], odd, r[20:0]};
        end else begin
            va = {e.vppn, odd, r[11:0]};
        end
    endtask

    task automatic pick_req(output tlb_req_t q);
        logic [31:0] r;
        take_bits(6, r);
        if (r[4]) begin
            q.valid = 1'b1;
            hit_va(tlb_idx_t'(r[3:0] % 4'd12), r[5], q.va);
        end else begin
            rand_va(q);
        end
    endtask

    always @(negedge clk) begin
        pend_t p;
        if (rstn) begin
            p = '0;
            if (pend_q.size() > 0 && pend_q[0].due == $time) begin
                p = pend_q.pop_front();
            end
            compare_port("fetch_res", fetch_res, p.f_exp);
            compare_port("data_res", data_res, p.d_exp);
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > LIMIT) begin
            stop_run($sformatf("timeout after %0d cycles", cycles));
        end
    end

    initial begin
        logic [31:0] r;
        clk = 1'b0;
        rstn = 1'b0;
        cycles = 0;
        fetch_req = '0;
        data_req = '0;
        csr_asid = '0;
        pg = 1'b0;
        dmw0_vseg = '0;
        dmw0_pseg = '0;
        dmw1_vseg = '0;
        dmw1_pseg = '0;
        tlb_we = 1'b0;
        tlb_windex = '0;
        tlb_wentry = '0;
        lfsr = 32'h9aad;
        f_nxt = '0;
        d_nxt = '0;
        we_nxt = 1'b0;
        idx_nxt = '0;
        ent_nxt = '0;
        asid_nxt = '0;
        for (int i = 0; i < `TLB_NUM; i++) begin
            shadow[i] = '0;
        end
        repeat (4) @(posedge clk);
        rstn <= 1'b1;
        repeat (4) tick();                      // Idle outputs stay zero.

        set_mode(1'b0, 3'd0, 3'd0, 3'd0, 3'd0);
        repeat (N_DIRECT) begin
            rand_va(f_nxt);
            rand_va(d_nxt);
            tick();
        end
        set_mode(1'b1, 3'd5, 3'd2, 3'd5, 3'd3); // Same segment, window 0 wins.
        repeat (N_WIN) begin
            rand_va(f_nxt);
            rand_va(d_nxt);
            f_nxt.va[31:29] = 3'd5;
            tick();
        end
        set_mode(1'b1, 3'd5, 3'd2, 3'd6, 3'd1);
        repeat (N_WIN) begin
            rand_va(f_nxt);
            rand_va(d_nxt);
            f_nxt.va[31:29] = 3'd5;
            d_nxt.va[31:29] = 3'd6;
            tick();
        end

        set_mode(1'b1, 3'd7, 3'd0, 3'd6, 3'd1);
        for (int big = 0; big < 2; big++) begin // 4K pages first, then 4M.
            for (int i = 0; i < N_MAP; i++) begin
                idx_nxt = tlb_idx_t'(i);
                make_entry(idx_nxt, big[0], ent_nxt);
                we_nxt = 1'b1;
                tick();
            end
            for (int i = 0; i < N_MAP; i++) begin
                asid_nxt = shadow[i].asid;
                f_nxt.valid = 1'b1;
                d_nxt.valid = 1'b1;
                hit_va(tlb_idx_t'(i), 1'b0, f_nxt.va);
                hit_va(tlb_idx_t'(i), 1'b1, d_nxt.va);
                tick();
            end
        end
        for (int i = 0; i < N_MAP; i += 2) begin
            asid_nxt = shadow[i].asid ^ 10'd1;  // Non-global under another ASID.
            f_nxt.valid = 1'b1;
            take_bits(1, r);
            hit_va(tlb_idx_t'(i), r[0], f_nxt.va);
            tick();
        end

        idx_nxt = 4'd2;
        make_entry(idx_nxt, 1'b0, ent_nxt);
        ent_nxt.even.v = 1'b0;
        we_nxt = 1'b1;
        tick();
        idx_nxt = 4'd3;
        make_entry(idx_nxt, 1'b0, ent_nxt);
        ent_nxt.e = 1'b0;                       // Disabled entry misses.
        we_nxt = 1'b1;
        tick();
        asid_nxt = shadow[2].asid;
        f_nxt.valid = 1'b1;
        d_nxt.valid = 1'b1;
        hit_va(4'd2, 1'b0, f_nxt.va);
        hit_va(4'd3, 1'b1, d_nxt.va);
        tick();

        for (int n = 0; n < N_RAND; n++) begin
            take_bits(6, r);
            asid_nxt = shadow[r[3:0] % 4'd12].asid;
            if (r[4]) begin
                idx_nxt = tlb_idx_t'(r[3:0] % 4'd12);
                make_entry(idx_nxt, r[5], ent_nxt);
                we_nxt = 1'b1;
            end
            pick_req(f_nxt);
            pick_req(d_nxt);
            tick();
        end
        repeat (3) tick();

        if (pend_q.size() == 0) begin
            $display("Simulation completed successfully");
            $finish;
        end else begin
            stop_run("results still pending at the end of the test");
        end
    end

endmodule

/* source/tlb.sv */
`include "tlb_config.svh"

module tlb
    import tlb_pkg::*;
(
    input  logic        clk,
    input  logic        rstn,
    input  asid_t       csr_asid,
    input  logic        pg,
    input  seg_t        dmw0_vseg,
    input  seg_t        dmw0_pseg,
    input  seg_t        dmw1_vseg,
    input  seg_t        dmw1_pseg,
    input  logic        tlb_we,
    input  tlb_idx_t    tlb_windex,
    input  tlb_entry_t  tlb_wentry,
    input  tlb_req_t    fetch_req,
    input  tlb_req_t    data_req,
    output tlb_result_t fetch_res,
    output tlb_result_t data_res
);

    tlb_entry_t entries [`TLB_NUM];    // Shared by both ports.
    tlb_match_t fetch_match;
    tlb_match_t data_match;

    tlb_entry_array i_entry_array (
        .clk     (clk),
        .rstn    (rstn),
        .we      (tlb_we),
        .windex  (tlb_windex),
        .wentry  (tlb_wentry),
        .entries (entries)
    );

    tlb_match_stage i_match_fetch (
        .clk     (clk),
        .rstn    (rstn),
        .entries (entries),
        .asid    (csr_asid),
        .req     (fetch_req),
        .match   (fetch_match)
    );

    tlb_match_stage i_match_data (
        .clk     (clk),
        .rstn    (rstn),
        .entries (entries),
        .asid    (csr_asid),
        .req     (data_req),
        .match   (data_match)
    );

    tlb_translate_stage i_xlat_fetch (
        .clk       (clk),
        .rstn      (rstn),
        .pg        (pg),
        .dmw0_vseg (dmw0_vseg),
        .dmw0_pseg (dmw0_pseg),
        .dmw1_vseg (dmw1_vseg),
        .dmw1_pseg (dmw1_pseg),
        .match     (fetch_match),
        .res       (fetch_res)
    );

    tlb_translate_stage i_xlat_data (
        .clk       (clk),
        .rstn      (rstn),
        .pg        (pg),
        .dmw0_vseg (dmw0_vseg),
        .dmw0_pseg (dmw0_pseg),
        .dmw1_vseg (dmw1_vseg),
        .dmw1_pseg (dmw1_pseg),
        .match     (data_match),
        .res       (data_res)
    );

endmodule

/* source/tlb_translate_stage.sv */
`include "tlb_config.svh"

module tlb_translate_stage
    import tlb_pkg::*;
(
    input  logic        clk,
    input  logic        rstn,
    input  logic        pg,
    input  seg_t        dmw0_vseg,
    input  seg_t        dmw0_pseg,
    input  seg_t        dmw1_vseg,
    input  seg_t        dmw1_pseg,
    input  tlb_match_t  match,
    output tlb_result_t res
);

    seg_t        va_seg;
    ppn_t        ppn;
    tlb_result_t nxt;

    assign va_seg = match.va[31:29];
    assign ppn    = match.half.ppn;

    always_comb begin
        nxt       = '0;
        nxt.valid = 1'b1;
        nxt.d     = 1'b1;               // Direct mappings are writable.
        if (!pg) begin
            nxt.pa = match.va;          // Direct address mode.
        end else if (va_seg == dmw0_vseg) begin
            nxt.pa = {dmw0_pseg, match.va[28:0]};
        end else if (va_seg == dmw1_vseg) begin
            nxt.pa = {dmw1_pseg, match.va[28:0]};
        end else begin
            // Page mapped through the entry half.
            if (match.is_4m) begin
                nxt.pa = {ppn[`TLB_PPN_W-1:9], match.va[20:0]};
            end else begin
                nxt.pa = {ppn, match.va[11:0]};
            end
            nxt.refill  = !match.hit;
            nxt.invalid = match.hit && !match.half.v;
            nxt.mat     = match.half.mat;
            nxt.plv     = match.half.plv;
            nxt.d       = match.half.d;
        end
    end

    // Idle cycles leave every field at zero.
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            res <= '0;
        end else if (match.valid) begin
            res <= nxt;
        end else begin
            res <= '0;
        end
    end

endmodule

/* source/tlb_match_stage.sv */
`include "tlb_config.svh"

module tlb_match_stage
    import tlb_pkg::*;
(
    input  logic       clk,
    input  logic       rstn,
    input  tlb_entry_t entries [`TLB_NUM],
    input  asid_t      asid,
    input  tlb_req_t   req,
    output tlb_match_t match
);

    logic [`TLB_NUM-1:0] hit_vec;
    logic [`TLB_NUM-1:0] odd_vec;   // Per entry, VA picks the odd half.
    logic [`TLB_NUM-1:0] big_vec;   // Per entry, 4M page.
    tlb_half_t           half_sel;
    logic                hit_4m;

    for (genvar i = 0; i < `TLB_NUM; i++) begin : g_cmp
        logic is_4k;
        logic asid_ok;
        logic vppn_ok;

        assign is_4k   = (entries[i].ps == 6'(`TLB_PS_4K));
        assign asid_ok = entries[i].g || (entries[i].asid == asid);

        // A 4M entry ignores the low VPPN bits.
        assign vppn_ok = is_4k ?
            (entries[i].vppn == req.va[31:13]) :
            (entries[i].vppn[`TLB_VPPN_W-1:9] == req.va[31:22]);

        assign hit_vec[i] = entries[i].e && asid_ok && vppn_ok;
        assign odd_vec[i] = is_4k ? req.va[12] : req.va[21];
        assign big_vec[i] = !is_4k;
    end

    // AND-OR mux, relies on at most one hit.
    always_comb begin
        half_sel = '0;
        hit_4m   = 1'b0;
        for (int i = 0; i < `TLB_NUM; i++) begin
            if (hit_vec[i]) begin
                half_sel |= odd_vec[i] ? entries[i].odd : entries[i].even;
                hit_4m   |= big_vec[i];
            end
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            match <= '0;
        end else begin
            match.valid <= req.valid;
            match.va    <= req.va;
            match.hit   <= |hit_vec;
            match.is_4m <= hit_4m;
            match.half  <= half_sel;    // Zero on a miss.
        end
    end

    // Duplicate entries must never be written for one ASID.
    a_hit_onehot: assert property (
        @(posedge clk) disable iff (!rstn)
        req.valid |-> $onehot0(hit_vec)
    );

endmodule

/* source/tlb_entry_array.sv */
`include "tlb_config.svh"

module tlb_entry_array
    import tlb_pkg::*;
(
    input  logic       clk,
    input  logic       rstn,
    input  logic       we,
    input  tlb_idx_t   windex,
    input  tlb_entry_t wentry,
    output tlb_entry_t entries [`TLB_NUM]
);

    // One-hot write select, one bit per entry.
    logic [`TLB_NUM-1:0] wsel;

    always_comb begin
        wsel = '0;
        if (we) begin
            for (int i = 0; i < `TLB_NUM; i++) begin
                if (windex == tlb_idx_t'(i)) begin
                    wsel[i] = 1'b1;
                end
            end
        end
    end

    // Each entry is its own register with a private enable.
    // All entries are read in parallel by both ports.
    for (genvar i = 0; i < `TLB_NUM; i++) begin : g_entry
        always_ff @(posedge clk or negedge rstn) begin
            if (!rstn) begin
                entries[i] <= '0;           // Disabled after reset.
            end else if (wsel[i]) begin
                entries[i] <= wentry;
            end
        end
    end

    // The match logic knows only the two page sizes.
    a_wentry_ps: assert property (
        @(posedge clk) disable iff (!rstn)
        we && wentry.e |->
            ((wentry.ps == 6'(`TLB_PS_4K)) || (wentry.ps == 6'(`TLB_PS_4M)))
    );

endmodule

/* source/tlb_pkg.sv */
`include "tlb_config.svh"

package tlb_pkg;

    typedef logic [31:0]              vaddr_t;
    typedef logic [31:0]              paddr_t;
    typedef logic [9:0]               asid_t;
    typedef logic [`TLB_VPPN_W-1:0]   vppn_t;
    typedef logic [`TLB_PPN_W-1:0]    ppn_t;
    typedef logic [2:0]               seg_t;   // Top three VA bits.
    typedef logic [`TLB_IDX_W-1:0]    tlb_idx_t;

    // Translation half of an entry.
    typedef struct packed {
        logic       v;
        logic       d;
        logic [1:0] mat;
        logic [1:0] plv;
        ppn_t       ppn;
    } tlb_half_t;

    typedef struct packed {
        logic       e;
        asid_t      asid;
        logic       g;
        logic [5:0] ps;
        vppn_t      vppn;
        tlb_half_t  even;
        tlb_half_t  odd;
    } tlb_entry_t;

    typedef struct packed {
        logic   valid;
        vaddr_t va;
    } tlb_req_t;

    // Between match and translate stages.
    typedef struct packed {
        logic      valid;
        vaddr_t    va;
        logic      hit;
        logic      is_4m;
        tlb_half_t half;
    } tlb_match_t;

    typedef struct packed {
        logic       valid;
        paddr_t     pa;
        logic       refill;
        logic       invalid;
        logic [1:0] mat;
        logic [1:0] plv;
        logic       d;
    } tlb_result_t;

endpackage

/* source/tlb_config.svh */
`ifndef TLB_CONFIG_SVH
`define TLB_CONFIG_SVH

// Number of entries in the shared array.
`define TLB_NUM 16

// Width of an entry index.
`define TLB_IDX_W 4

// Virtual page pair number, VA bits 31 to 13.
`define TLB_VPPN_W 19

// Physical page frame number.
`define TLB_PPN_W 20

// Page-size codes as held in the entry.
`define TLB_PS_4K 12
`define TLB_PS_4M 21

`endif
